// ==== common.sv ====
package common;

    localparam int XLEN          = 64;
    localparam int REG_COUNT     = 32;
    localparam int REG_IDX_W     = 5;
    localparam int INSTR_W       = 32;
    localparam int ALUOP_W       = 3;
    localparam int MEMMODE_W     = 4;
    localparam int FWD_SRC_COUNT = 2;  // the number of forwarding sources and of operands.

    localparam logic [ALUOP_W-1:0] ALU_ADD = 3'd0;
    localparam logic [ALUOP_W-1:0] ALU_SUB = 3'd1;
    localparam logic [ALUOP_W-1:0] ALU_AND = 3'd2;
    localparam logic [ALUOP_W-1:0] ALU_OR  = 3'd3;
    localparam logic [ALUOP_W-1:0] ALU_XOR = 3'd4;
    localparam logic [ALUOP_W-1:0] ALU_SLL = 3'd5;
    localparam logic [ALUOP_W-1:0] ALU_SRL = 3'd6;
    localparam logic [ALUOP_W-1:0] ALU_SRA = 3'd7;

    // the top bit flags an unsigned load and the low bits hold the byte count minus one.
    localparam logic [MEMMODE_W-1:0] MEM_B  = 4'b0000;
    localparam logic [MEMMODE_W-1:0] MEM_H  = 4'b0001;
    localparam logic [MEMMODE_W-1:0] MEM_W  = 4'b0011;
    localparam logic [MEMMODE_W-1:0] MEM_D  = 4'b0111;
    localparam logic [MEMMODE_W-1:0] MEM_BU = 4'b1000;
    localparam logic [MEMMODE_W-1:0] MEM_HU = 4'b1001;
    localparam logic [MEMMODE_W-1:0] MEM_WU = 4'b1011;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM32  = 7'b0011011;
    localparam logic [6:0] OP_REG32  = 7'b0111011;

endpackage

// ==== mainDecoder.sv ====
`timescale 1ns/1ps

module mainDecoder (
    input  logic [common::INSTR_W-1:0]   instr,
    output logic [common::REG_IDX_W-1:0] rs1Idx,
    output logic [common::REG_IDX_W-1:0] rs2Idx,
    output logic [common::REG_IDX_W-1:0] wd,
    output logic [common::XLEN-1:0]      imm,
    output logic [common::ALUOP_W-1:0]   aluOp,
    output logic                         srcB,
    output logic                         isBranch,
    output logic                         isWriteBack,
    output logic                         isMemRead,
    output logic                         isMemWrite,
    output logic [common::MEMMODE_W-1:0] memMode,
    output logic                         rv64,
    output logic                         legal
);
    import common::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7Zero;
    logic       f7Alt;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immS;
    logic [XLEN-1:0] immB;
    logic [XLEN-1:0] immU;
    logic [XLEN-1:0] immJ;

    function automatic logic [ALUOP_W-1:0] aluSel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  aluSel = alt ? ALU_SUB : ALU_ADD;
            3'b001:  aluSel = ALU_SLL;
            3'b100:  aluSel = ALU_XOR;
            3'b101:  aluSel = alt ? ALU_SRA : ALU_SRL;
            3'b110:  aluSel = ALU_OR;
            3'b111:  aluSel = ALU_AND;
            default: aluSel = ALU_SUB;  // slt and sltu; EX reads funct3 from exInstr.
        endcase
    endfunction

    function automatic logic [MEMMODE_W-1:0] memSel(input logic [2:0] f3);
        case (f3)
            3'b000:  memSel = MEM_B;
            3'b001:  memSel = MEM_H;
            3'b010:  memSel = MEM_W;
            3'b011:  memSel = MEM_D;
            3'b100:  memSel = MEM_BU;
            3'b101:  memSel = MEM_HU;
            default: memSel = MEM_WU;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign f7Zero = (funct7 == 7'h00);
    assign f7Alt  = (funct7 == 7'h20);

    assign immI = {{52{instr[31]}}, instr[31:20]};
    assign immS = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign immJ = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        rs1Idx      = instr[19:15];
        rs2Idx      = '0;
        wd          = instr[11:7];
        imm         = immI;
        aluOp       = ALU_ADD;
        srcB        = 1'b1;
        isBranch    = 1'b0;
        isWriteBack = 1'b1;
        isMemRead   = 1'b0;
        isMemWrite  = 1'b0;
        memMode     = memSel(funct3);
        rv64        = 1'b0;
        legal       = 1'b1;
        case (opcode)
            OP_LUI, OP_AUIPC: begin
                rs1Idx = '0;
                imm    = immU;
            end
            OP_JAL: begin
                rs1Idx = '0;
                imm    = immJ;
            end
            OP_JALR: legal = (funct3 == 3'b000);
            OP_BRANCH: begin
                rs2Idx      = instr[24:20];
                imm         = immB;
                aluOp       = ALU_SUB;
                srcB        = 1'b0;
                isBranch    = 1'b1;
                isWriteBack = 1'b0;
                legal       = (funct3[2:1] != 2'b01);
            end
            OP_LOAD: begin
                isMemRead = 1'b1;
                legal     = (funct3 != 3'b111);
            end
            OP_STORE: begin
                rs2Idx      = instr[24:20];
                imm         = immS;
                isWriteBack = 1'b0;
                isMemWrite  = 1'b1;
                legal       = ~funct3[2];
            end
            OP_IMM: begin
                aluOp = aluSel(funct3, funct3 == 3'b101 && instr[30]);
                if (funct3 == 3'b001) begin
                    legal = (funct7[6:1] == 6'h00);  // six-bit shamt in RV64.
                end else if (funct3 == 3'b101) begin
                    legal = (funct7[6:1] == 6'h00) || (funct7[6:1] == 6'h10);
                end
            end
            OP_REG: begin
                rs2Idx = instr[24:20];
                srcB   = 1'b0;
                aluOp  = aluSel(funct3, instr[30]);
                legal  = f7Zero || (f7Alt && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OP_IMM32: begin
                rv64  = 1'b1;
                aluOp = aluSel(funct3, funct3 == 3'b101 && instr[30]);
                legal = (funct3 == 3'b000) || (funct3 == 3'b001 && f7Zero)
                    || (funct3 == 3'b101 && (f7Zero || f7Alt));
            end
            OP_REG32: begin
                rs2Idx = instr[24:20];
                srcB   = 1'b0;
                rv64   = 1'b1;
                aluOp  = aluSel(funct3, instr[30]);
                legal  = ((funct3 == 3'b000 || funct3 == 3'b101) && (f7Zero || f7Alt))
                    || (funct3 == 3'b001 && f7Zero);
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            isBranch    = 1'b0;
            isWriteBack = 1'b0;
            isMemRead   = 1'b0;
            isMemWrite  = 1'b0;
        end
        if (!isWriteBack) begin
            wd = '0;  // no destination, so nothing downstream can match it.
        end
    end

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wbEn,
    input  logic [common::REG_IDX_W-1:0] wbAddr,
    input  logic [common::XLEN-1:0]      wbData,
    input  logic [common::REG_IDX_W-1:0] rdAddr1,
    input  logic [common::REG_IDX_W-1:0] rdAddr2,
    output logic [common::XLEN-1:0]      rdData1,
    output logic [common::XLEN-1:0]      rdData2
);
    import common::*;

    logic [XLEN-1:0] regs [REG_COUNT-1:1];  // x0 has no storage.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && wbAddr != '0) begin
            regs[wbAddr] <= wbData;
        end
    end

    // reads see a same-cycle write only through the forwarding sources.
    assign rdData1 = (rdAddr1 == '0) ? '0 : regs[rdAddr1];
    assign rdData2 = (rdAddr2 == '0) ? '0 : regs[rdAddr2];

endmodule

// ==== operandForward.sv ====
`timescale 1ns/1ps

module operandForward (
    input  logic [common::REG_IDX_W-1:0] idx,
    input  logic [common::XLEN-1:0]      regData,
    input  logic                         fwd1Valid,
    input  logic                         fwd1IsWb,
    input  logic [common::REG_IDX_W-1:0] fwd1Wd,
    input  logic [common::XLEN-1:0]      fwd1Data,
    input  logic                         fwd2Valid,
    input  logic                         fwd2IsWb,
    input  logic [common::REG_IDX_W-1:0] fwd2Wd,
    input  logic [common::XLEN-1:0]      fwd2Data,
    output logic [common::XLEN-1:0]      operand
);

    logic hit1;
    logic hit2;

    // x0 is never forwarded.
    assign hit1 = fwd1Valid & fwd1IsWb & (fwd1Wd == idx) & (idx != '0);
    assign hit2 = fwd2Valid & fwd2IsWb & (fwd2Wd == idx) & (idx != '0);

    // source 2 wins over source 1.
    assign operand = hit2 ? fwd2Data : (hit1 ? fwd1Data : regData);

endmodule

// ==== decodeRegister.sv ====
`timescale 1ns/1ps

module decodeRegister (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         enable,
    input  logic                         inValid,
    input  logic                         legal,
    input  logic [common::XLEN-1:0]      instrAddr,
    input  logic [common::INSTR_W-1:0]   instr,
    input  logic [common::XLEN-1:0]      pcPlus4,
    input  logic [common::XLEN-1:0]      rs1Data,
    input  logic [common::XLEN-1:0]      rs2Data,
    input  logic [common::XLEN-1:0]      imm,
    input  logic [common::REG_IDX_W-1:0] wd,
    input  logic [common::ALUOP_W-1:0]   aluOp,
    input  logic                         srcB,
    input  logic                         isBranch,
    input  logic                         isWriteBack,
    input  logic                         isMemRead,
    input  logic                         isMemWrite,
    input  logic [common::MEMMODE_W-1:0] memMode,
    input  logic                         rv64,
    output logic                         exValid,
    output logic [common::XLEN-1:0]      exInstrAddr,
    output logic [common::INSTR_W-1:0]   exInstr,
    output logic [common::XLEN-1:0]      exPcPlus4,
    output logic [common::XLEN-1:0]      exRs1Data,
    output logic [common::XLEN-1:0]      exRs2Data,
    output logic [common::XLEN-1:0]      exImm,
    output logic [common::REG_IDX_W-1:0] exWd,
    output logic [common::ALUOP_W-1:0]   exAluOp,
    output logic                         exSrcB,
    output logic                         exIsBranch,
    output logic                         exIsWriteBack,
    output logic                         exIsMemRead,
    output logic                         exIsMemWrite,
    output logic [common::MEMMODE_W-1:0] exMemMode,
    output logic                         exRv64
);

    always_ff @(posedge clk) begin
        if (rst) begin
            exValid       <= 1'b0;
            exInstrAddr   <= '0;
            exInstr       <= '0;
            exPcPlus4     <= '0;
            exRs1Data     <= '0;
            exRs2Data     <= '0;
            exImm         <= '0;
            exWd          <= '0;
            exAluOp       <= '0;
            exSrcB        <= 1'b0;
            exIsBranch    <= 1'b0;
            exIsWriteBack <= 1'b0;
            exIsMemRead   <= 1'b0;
            exIsMemWrite  <= 1'b0;
            exMemMode     <= '0;
            exRv64        <= 1'b0;
        end else if (enable) begin
            exValid       <= inValid & legal;  // an illegal opcode leaves a bubble.
            exInstrAddr   <= instrAddr;
            exInstr       <= instr;
            exPcPlus4     <= pcPlus4;
            exRs1Data     <= rs1Data;
            exRs2Data     <= rs2Data;
            exImm         <= imm;
            exWd          <= wd;
            exAluOp       <= aluOp;
            exSrcB        <= srcB;
            exIsBranch    <= isBranch;
            exIsWriteBack <= isWriteBack;
            exIsMemRead   <= isMemRead;
            exIsMemWrite  <= isMemWrite;
            exMemMode     <= memMode;
            exRv64        <= rv64;
        end
    end

endmodule

// ==== decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         instrValid,
    input  logic [common::INSTR_W-1:0]   instr,
    input  logic [common::XLEN-1:0]      instrAddr,
    input  logic [common::XLEN-1:0]      pcPlus4,
    input  logic                         bubbleHold,
    input  logic                         fwd1Valid,
    input  logic                         fwd1IsWb,
    input  logic [common::REG_IDX_W-1:0] fwd1Wd,
    input  logic [common::XLEN-1:0]      fwd1Data,
    input  logic                         fwd2Valid,
    input  logic                         fwd2IsWb,
    input  logic [common::REG_IDX_W-1:0] fwd2Wd,
    input  logic [common::XLEN-1:0]      fwd2Data,
    input  logic                         wbEn,
    input  logic [common::REG_IDX_W-1:0] wbAddr,
    input  logic [common::XLEN-1:0]      wbData,
    output logic                         lwHold,
    output logic                         exValid,
    output logic [common::XLEN-1:0]      exInstrAddr,
    output logic [common::INSTR_W-1:0]   exInstr,
    output logic [common::XLEN-1:0]      exPcPlus4,
    output logic [common::XLEN-1:0]      exRs1Data,
    output logic [common::XLEN-1:0]      exRs2Data,
    output logic [common::XLEN-1:0]      exImm,
    output logic [common::REG_IDX_W-1:0] exWd,
    output logic [common::ALUOP_W-1:0]   exAluOp,
    output logic                         exSrcB,
    output logic                         exIsBranch,
    output logic                         exIsWriteBack,
    output logic                         exIsMemRead,
    output logic                         exIsMemWrite,
    output logic [common::MEMMODE_W-1:0] exMemMode,
    output logic                         exRv64
);
    import common::*;

    logic [REG_IDX_W-1:0] rsIdx   [FWD_SRC_COUNT];
    logic [XLEN-1:0]      rsData  [FWD_SRC_COUNT];
    logic [XLEN-1:0]      operand [FWD_SRC_COUNT];
    logic [REG_IDX_W-1:0] wd;
    logic [XLEN-1:0]      imm;
    logic [ALUOP_W-1:0]   aluOp;
    logic                 srcB;
    logic                 isBranch;
    logic                 isWriteBack;
    logic                 isMemRead;
    logic                 isMemWrite;
    logic [MEMMODE_W-1:0] memMode;
    logic                 rv64;
    logic                 legal;

    assign lwHold = instrValid & isMemRead;  // the hazard unit needs this level in the same cycle.

    mainDecoder mainDecoder_inst (
        .instr(instr), .rs1Idx(rsIdx[0]), .rs2Idx(rsIdx[1]), .wd(wd), .imm(imm),
        .aluOp(aluOp), .srcB(srcB), .isBranch(isBranch), .isWriteBack(isWriteBack),
        .isMemRead(isMemRead), .isMemWrite(isMemWrite), .memMode(memMode),
        .rv64(rv64), .legal(legal)
    );

    regFile regFile_inst (
        .clk(clk), .rst(rst), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
        .rdAddr1(rsIdx[0]), .rdAddr2(rsIdx[1]), .rdData1(rsData[0]), .rdData2(rsData[1])
    );

    for (genvar i = 0; i < FWD_SRC_COUNT; i++) begin : fwdGen
        operandForward operandForward_inst (
            .idx(rsIdx[i]), .regData(rsData[i]),
            .fwd1Valid(fwd1Valid), .fwd1IsWb(fwd1IsWb), .fwd1Wd(fwd1Wd), .fwd1Data(fwd1Data),
            .fwd2Valid(fwd2Valid), .fwd2IsWb(fwd2IsWb), .fwd2Wd(fwd2Wd), .fwd2Data(fwd2Data),
            .operand(operand[i])
        );
    end

    decodeRegister decodeRegister_inst (
        .clk(clk), .rst(rst), .enable(~bubbleHold), .inValid(instrValid), .legal(legal),
        .instrAddr(instrAddr), .instr(instr), .pcPlus4(pcPlus4),
        .rs1Data(operand[0]), .rs2Data(operand[1]), .imm(imm), .wd(wd), .aluOp(aluOp),
        .srcB(srcB), .isBranch(isBranch), .isWriteBack(isWriteBack),
        .isMemRead(isMemRead), .isMemWrite(isMemWrite), .memMode(memMode), .rv64(rv64),
        .exValid(exValid), .exInstrAddr(exInstrAddr), .exInstr(exInstr),
        .exPcPlus4(exPcPlus4), .exRs1Data(exRs1Data), .exRs2Data(exRs2Data),
        .exImm(exImm), .exWd(exWd), .exAluOp(exAluOp), .exSrcB(exSrcB),
        .exIsBranch(exIsBranch), .exIsWriteBack(exIsWriteBack),
        .exIsMemRead(exIsMemRead), .exIsMemWrite(exIsMemWrite),
        .exMemMode(exMemMode), .exRv64(exRv64)
    );

endmodule

// ==== decodeStage_assertions.sv ====
`timescale 1ns/1ps

module decodeStage_assertions (
    input logic                         clk,
    input logic                         rst,
    input logic                         instrValid,
    input logic [common::INSTR_W-1:0]   instr,
    input logic                         bubbleHold,
    input logic                         lwHold,
    input logic                         exValid,
    input logic [common::XLEN-1:0]      exInstrAddr,
    input logic [common::INSTR_W-1:0]   exInstr,
    input logic [common::XLEN-1:0]      exPcPlus4,
    input logic [common::XLEN-1:0]      exRs1Data,
    input logic [common::XLEN-1:0]      exRs2Data,
    input logic [common::XLEN-1:0]      exImm,
    input logic [common::REG_IDX_W-1:0] exWd,
    input logic [common::ALUOP_W-1:0]   exAluOp,
    input logic                         exSrcB,
    input logic                         exIsBranch,
    input logic                         exIsWriteBack,
    input logic                         exIsMemRead,
    input logic                         exIsMemWrite,
    input logic [common::MEMMODE_W-1:0] exMemMode,
    input logic                         exRv64
);
    import common::*;

    int assertFails = 0;

    resetClears: assert property (@(posedge clk) rst |=> !exValid)
        else begin $error("exValid high after reset"); assertFails++; end

    holdStable: assert property (@(posedge clk) disable iff (rst)
        bubbleHold |=> $stable({exValid, exInstrAddr, exInstr, exPcPlus4, exRs1Data,
            exRs2Data, exImm, exWd, exAluOp, exSrcB, exIsBranch, exIsWriteBack,
            exIsMemRead, exIsMemWrite, exMemMode, exRv64}))
        else begin $error("ex outputs changed under bubbleHold"); assertFails++; end

    // funct3 of 111 is no load in RV64I.
    loadHold: assert property (@(posedge clk) disable iff (rst)
        lwHold == (instrValid && instr[6:0] == OP_LOAD && instr[14:12] != 3'b111))
        else begin $error("lwHold does not follow the presented load"); assertFails++; end

    memExclusive: assert property (@(posedge clk) !(exIsMemRead && exIsMemWrite))
        else begin $error("memory read and write both set"); assertFails++; end

endmodule

bind decodeStage decodeStage_assertions decodeStage_assertions_inst (.*);

// ==== tb_decodeStage.sv ====
`timescale 1ns/1ps

module tb_decodeStage;
    import common::*;

    logic clk, rst, instrValid, bubbleHold, wbEn, lwHold, exValid;
    logic [INSTR_W-1:0] instr, exInstr;
    logic [XLEN-1:0] instrAddr, pcPlus4, fwd1Data, fwd2Data, wbData;
    logic fwd1Valid, fwd1IsWb, fwd2Valid, fwd2IsWb;
    logic [REG_IDX_W-1:0] fwd1Wd, fwd2Wd, wbAddr, exWd;
    logic [XLEN-1:0] exInstrAddr, exPcPlus4, exRs1Data, exRs2Data, exImm;
    logic [ALUOP_W-1:0] exAluOp;
    logic exSrcB, exIsBranch, exIsWriteBack, exIsMemRead, exIsMemWrite, exRv64;
    logic [MEMMODE_W-1:0] exMemMode;

    logic [XLEN-1:0] shadow [REG_COUNT];
    int curErrs = 0;
    int testsRun = 0;
    int testsFailed = 0;

    logic [2:0] immF3 [7] = '{3'd0, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
    logic [2:0] immAlu [7] = '{ALU_ADD, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA};
    logic [2:0] regF3 [8] = '{3'd0, 3'd0, 3'd1, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic [6:0] regF7 [8] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
    logic [2:0] regAlu [8] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR, ALU_AND};
    logic [3:0] loadMode [7] = '{4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1000, 4'b1001, 4'b1011};

    decodeStage decodeStage_inst (.*);

    always #50 clk = ~clk;

    initial begin
        #5_000_000;
        $display("timeout: the simulation did not reach its end in time");
        $display("sim failed");
        $finish;
    end

    function automatic logic [63:0] rnd64();
        return {$urandom(), $urandom()};
    endfunction

    function automatic logic [4:0] randIdx(input bit nonZero);
        logic [31:0] r;
        r = $urandom();
        if (nonZero && r[4:0] == 5'd0) return 5'd1;
        return r[4:0];
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    // reference forwarding gives source 2 priority and never forwards x0.
    function automatic logic [63:0] expectOperand(input logic [4:0] idx);
        if (idx == 5'd0) return 64'd0;
        if (fwd2Valid && fwd2IsWb && fwd2Wd == idx) return fwd2Data;
        if (fwd1Valid && fwd1IsWb && fwd1Wd == idx) return fwd1Data;
        return shadow[idx];
    endfunction

    task automatic checkVal(input string test, input string field, input logic [63:0] exp,
            input logic [63:0] act);
        if (exp !== act) begin
            $display("FAIL %s %s expected %h actual %h", test, field, exp, act);
            curErrs++;
        end
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (curErrs == 0) begin
            $display("PASS %s", name);
        end else begin
            testsFailed++;
            $display("FAIL %s with %0d mismatches", name, curErrs);
        end
        curErrs = 0;
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic drive(input logic v, input logic [31:0] ins);
        logic [63:0] a;
        a = rnd64();
        instrValid = v;
        instr = ins;
        instrAddr = {a[63:2], 2'b00};
        pcPlus4 = {a[63:2], 2'b00} + 64'd4;
    endtask

    task automatic present(input logic v, input logic [31:0] ins);
        drive(v, ins);
        tick();
    endtask

    task automatic writeReg(input logic [4:0] addr, input logic [63:0] data);
        instrValid = 1'b0;
        wbEn = 1'b1;
        wbAddr = addr;
        wbData = data;
        tick();
        wbEn = 1'b0;
        if (addr != 5'd0) shadow[addr] = data;
    endtask

    task automatic setFwd(input logic v1, input logic w1, input logic [4:0] d1,
            input logic v2, input logic w2, input logic [4:0] d2);
        fwd1Valid = v1;
        fwd1IsWb = w1;
        fwd1Wd = d1;
        fwd1Data = rnd64();
        fwd2Valid = v2;
        fwd2IsWb = w2;
        fwd2Wd = d2;
        fwd2Data = rnd64();
    endtask

    task automatic checkDecode(input string name, input logic [63:0] eImm, input bit immCare,
            input logic [4:0] eWd, input logic [2:0] eAlu, input bit eSrcB, input bit eBr,
            input bit eWb, input bit eRd, input bit eWr, input logic [3:0] eMode,
            input bit eRv64);
        checkVal(name, "exValid", 64'd1, 64'(exValid));
        checkVal(name, "exInstr", 64'(instr), 64'(exInstr));
        checkVal(name, "exPcPlus4", pcPlus4, exPcPlus4);
        if (immCare) checkVal(name, "exImm", eImm, exImm);
        checkVal(name, "exWd", 64'(eWd), 64'(exWd));
        checkVal(name, "exAluOp", 64'(eAlu), 64'(exAluOp));
        checkVal(name, "exSrcB", 64'(eSrcB), 64'(exSrcB));
        checkVal(name, "exIsBranch", 64'(eBr), 64'(exIsBranch));
        checkVal(name, "exIsWriteBack", 64'(eWb), 64'(exIsWriteBack));
        checkVal(name, "exIsMemRead", 64'(eRd), 64'(exIsMemRead));
        checkVal(name, "exIsMemWrite", 64'(eWr), 64'(exIsMemWrite));
        if (eRd || eWr) checkVal(name, "exMemMode", 64'(eMode), 64'(exMemMode));
        checkVal(name, "exRv64", 64'(eRv64), 64'(exRv64));
    endtask

    initial begin
        logic [31:0] ins;
        logic [31:0] r;
        logic [4:0] ra, rb, rd, tgt;
        logic [63:0] d, snap;
        logic [11:0] i12;
        logic [12:0] i13;
        logic [20:0] i21;
        int waited;

        void'($urandom(32'ha065e437));
        clk = 1'b0;
        rst = 1'b1;
        bubbleHold = 1'b0;
        wbEn = 1'b0;
        wbAddr = '0;
        wbData = '0;
        instrValid = 1'b0;
        instr = '0;
        instrAddr = '0;
        pcPlus4 = '0;
        setFwd(1'b0, 1'b0, 5'd0, 1'b0, 1'b0, 5'd0);
        for (int i = 0; i < REG_COUNT; i++) shadow[i] = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        waited = 0;
        while (exValid !== 1'b0 && waited < 10) begin
            tick();
            waited++;
        end
        if (exValid !== 1'b0) begin
            $display("exValid did not settle low after reset within 10 cycles");
            curErrs++;
        end
        for (int i = 0; i < 3; i++) begin
            present(1'b1, encR(7'h00, randIdx(0), randIdx(0), 3'd0, randIdx(1), OP_REG));
            checkVal("reset", "exRs1Data", 64'd0, exRs1Data);
            checkVal("reset", "exRs2Data", 64'd0, exRs2Data);
        end
        endTest("reset");

        for (int i = 0; i < 7; i++) begin
            r = $urandom();
            rd = randIdx(0);
            i12 = (i < 4) ? r[11:0] : {(i == 6) ? 6'h10 : 6'h00, r[5:0]};
            present(1'b1, {i12, randIdx(0), immF3[i], rd, OP_IMM});
            checkDecode("decode OP-IMM", {{52{i12[11]}}, i12}, 1, rd, immAlu[i], 1, 0, 1,
                0, 0, 4'd0, 0);
        end
        for (int i = 0; i < 8; i++) begin
            rd = randIdx(0);
            present(1'b1, encR(regF7[i], randIdx(0), randIdx(0), regF3[i], rd, OP_REG));
            checkDecode("decode OP", 64'd0, 0, rd, regAlu[i], 0, 0, 1, 0, 0, 4'd0, 0);
        end
        r = $urandom();
        rd = randIdx(0);
        present(1'b1, {r[19:0], rd, OP_LUI});
        checkDecode("decode LUI", {{32{r[19]}}, r[19:0], 12'h000}, 1, rd, ALU_ADD, 1, 0, 1,
            0, 0, 4'd0, 0);
        present(1'b1, {r[31:12], rd, OP_AUIPC});
        checkDecode("decode AUIPC", {{32{r[31]}}, r[31:12], 12'h000}, 1, rd, ALU_ADD, 1, 0,
            1, 0, 0, 4'd0, 0);
        i21 = {r[20:1], 1'b0};
        present(1'b1, {i21[20], i21[10:1], i21[11], i21[19:12], rd, OP_JAL});
        checkDecode("decode JAL", {{43{i21[20]}}, i21}, 1, rd, ALU_ADD, 1, 0, 1, 0, 0,
            4'd0, 0);
        present(1'b1, {r[11:0], randIdx(0), 3'd0, rd, OP_JALR});
        checkDecode("decode JALR", {{52{r[11]}}, r[11:0]}, 1, rd, ALU_ADD, 1, 0, 1, 0, 0,
            4'd0, 0);
        for (int i = 0; i < 6; i++) begin
            r = $urandom();
            i13 = {r[12:1], 1'b0};
            ins = {i13[12], i13[10:5], randIdx(0), randIdx(0), (i < 2) ? 3'(i) : 3'(i + 2),
                i13[4:1], i13[11], OP_BRANCH};
            present(1'b1, ins);
            checkDecode("decode branch", {{51{i13[12]}}, i13}, 1, 5'd0, ALU_SUB, 0, 1, 0, 0,
                0, 4'd0, 0);
        end
        for (int i = 0; i < 7; i++) begin
            r = $urandom();
            rd = randIdx(0);
            present(1'b1, {r[11:0], randIdx(0), 3'(i), rd, OP_LOAD});
            checkDecode("decode load", {{52{r[11]}}, r[11:0]}, 1, rd, ALU_ADD, 1, 0, 1, 1,
                0, loadMode[i], 0);
        end
        for (int i = 0; i < 4; i++) begin
            r = $urandom();
            present(1'b1, {r[11:5], randIdx(0), randIdx(0), 3'(i), r[4:0], OP_STORE});
            checkDecode("decode store", {{52{r[11]}}, r[11:0]}, 1, 5'd0, ALU_ADD, 1, 0, 0, 0,
                1, loadMode[i], 0);
        end
        r = $urandom();
        rd = randIdx(0);
        present(1'b1, {r[11:0], randIdx(0), 3'd0, rd, OP_IMM32});
        checkDecode("decode ADDIW", {{52{r[11]}}, r[11:0]}, 1, rd, ALU_ADD, 1, 0, 1, 0, 0,
            4'd0, 1);
        present(1'b1, encR(7'h20, randIdx(0), randIdx(0), 3'd0, rd, OP_REG32));
        checkDecode("decode SUBW", 64'd0, 0, rd, ALU_SUB, 0, 0, 1, 0, 0, 4'd0, 1);
        present(1'b1, {r[31:7], 7'b1111111});
        checkVal("decode unknown", "exValid", 64'd0, 64'(exValid));
        checkVal("decode unknown", "exIsWriteBack", 64'd0, 64'(exIsWriteBack));
        endTest("decode");

        for (int i = 0; i < 6; i++) begin
            ra = (i == 5) ? 5'd0 : randIdx(1);  // the last pass targets x0.
            d = rnd64();
            writeReg(ra, d);
            present(1'b1, encR(7'h00, ra, ra, 3'd0, randIdx(0), OP_REG));
            checkVal("regfile", "exRs1Data", (ra == 5'd0) ? 64'd0 : d, exRs1Data);
            checkVal("regfile", "exRs2Data", (ra == 5'd0) ? 64'd0 : d, exRs2Data);
        end
        endTest("regfile");

        ra = randIdx(1);
        rb = (ra == 5'd31) ? 5'd1 : ra + 5'd1;
        writeReg(ra, rnd64());
        writeReg(rb, rnd64());
        for (int k = 0; k < 2; k++) begin
            for (int c = 0; c < 7; c++) begin
                tgt = (c == 6) ? 5'd0 : ((k == 0) ? ra : rb);
                case (c)
                    0: setFwd(1, 1, tgt, 0, 0, 5'd0);
                    1: setFwd(0, 0, 5'd0, 1, 1, tgt);
                    2: setFwd(1, 1, tgt, 1, 1, tgt);
                    3: setFwd(1, 1, ~tgt, 1, 1, tgt ^ 5'h10);
                    4: setFwd(1, 0, tgt, 1, 0, tgt);
                    5: setFwd(0, 1, tgt, 0, 1, tgt);
                    default: setFwd(1, 1, tgt, 1, 1, tgt);
                endcase
                ins = encR(7'h00, (k == 1) ? tgt : rb, (k == 0) ? tgt : ra, 3'd0, 5'd3, OP_REG);
                present(1'b1, ins);
                checkVal("forward", "exRs1Data", expectOperand(ins[19:15]), exRs1Data);
                checkVal("forward", "exRs2Data", expectOperand(ins[24:20]), exRs2Data);
            end
        end
        setFwd(0, 0, 5'd0, 0, 0, 5'd0);
        endTest("forward");

        ins = encR(7'h00, rb, ra, 3'd0, 5'd4, OP_REG);
        present(1'b1, ins);
        snap = instrAddr;
        bubbleHold = 1'b1;
        for (int i = 0; i < 4; i++) begin
            present(1'b1, {$urandom()} | 32'h33);
            checkVal("hold", "exInstr", 64'(ins), 64'(exInstr));
            checkVal("hold", "exInstrAddr", snap, exInstrAddr);
        end
        bubbleHold = 1'b0;
        ins = encR(7'h00, ra, rb, 3'd4, 5'd5, OP_REG);
        present(1'b1, ins);
        checkVal("hold", "exInstr after release", 64'(ins), 64'(exInstr));
        endTest("hold");

        present(1'b1, {12'h010, randIdx(0), 3'd3, randIdx(1), OP_LOAD});
        checkVal("load hold", "lwHold for load", 64'd1, 64'(lwHold));
        present(1'b1, {7'h00, randIdx(0), randIdx(0), 3'd3, 5'd8, OP_STORE});
        checkVal("load hold", "lwHold for store", 64'd0, 64'(lwHold));
        present(1'b0, {12'h010, randIdx(0), 3'd3, randIdx(1), OP_LOAD});
        checkVal("load hold", "lwHold for invalid load", 64'd0, 64'(lwHold));
        endTest("load hold");

        $display("%0d tests, %0d passed, %0d failed, %0d assertion failures", testsRun,
            testsRun - testsFailed, testsFailed,
            decodeStage_inst.decodeStage_assertions_inst.assertFails);
        if (testsFailed == 0 && decodeStage_inst.decodeStage_assertions_inst.assertFails == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== rvDecodeStage.f ====
common.sv
mainDecoder.sv
regFile.sv
operandForward.sv
decodeRegister.sv
decodeStage.sv
decodeStage_assertions.sv
tb_decodeStage.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the decode stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rvDecodeStage.f \
    --top-module tb_decodeStage -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^sim passed$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
